// File: rtl/ddr_capture.sv
/* DDR input capture on write_clk for all groups. dq_in must be stable around both edges,
   and there is no strobe delay or per-bit deskew here */
`timescale 1ns/1ps
`default_nettype none

module ddr_capture
	import rdp_param_pkg::*;
	import rdp_types_pkg::*;
(
	input  wire logic write_clk,
	input  wire logic arst_n,
	input  wire logic [NUM_GROUPS-1:0][DQ_GROUP_WIDTH-1:0] dq_in,
	output capture_word_t [NUM_GROUPS-1:0] cap_word
);

	// Samples taken on each edge of write_clk
	logic [NUM_GROUPS-1:0][DQ_GROUP_WIDTH-1:0] rise_q;
	logic [NUM_GROUPS-1:0][DQ_GROUP_WIDTH-1:0] fall_q;

	// The rising sample is the first slot of the full-rate pair
	always_ff @(posedge write_clk or negedge arst_n)
	begin
		if (!arst_n)
			rise_q <= '0;
		else
			rise_q <= dq_in;
	end

	// The falling sample completes the pair half a cycle later
	always_ff @(negedge write_clk or negedge arst_n)
	begin
		if (!arst_n)
			fall_q <= '0;
		else
			fall_q <= dq_in;
	end

	// Repack both halves on the next rising edge
	// The old rise_q is read here, so the pair always belongs to one write_clk cycle
	always_ff @(posedge write_clk or negedge arst_n)
	begin
		if (!arst_n)
			cap_word <= '0;
		else
			for (int g = 0; g < NUM_GROUPS; g++)
			begin
				cap_word[g].t0 <= rise_q[g];
				cap_word[g].t1 <= fall_q[g];
			end
	end

endmodule

`default_nettype wire

// File: rtl/rdp_cfg_regs.sv
/* Control and status registers on read_clk. Status bits are sticky with write-one-to-clear,
   and a new event in the clearing cycle keeps its bit set */
`timescale 1ns/1ps
`default_nettype none

module rdp_cfg_regs
	import rdp_param_pkg::*;
	import rdp_types_pkg::*;
(
	input  wire logic read_clk,
	input  wire logic arst_n,
	input  wire cfg_bus_t cfg,
	input  wire logic [NUM_GROUPS-1:0] overflow_evt,
	input  wire logic [NUM_GROUPS-1:0] underflow_evt,
	output rdp_cfg_t cfg_out,
	output logic [CFG_DATA_WIDTH-1:0] cfg_rdata
);

	// Underflow flags sit above the overflow flags
	logic [2*NUM_GROUPS-1:0] status;
	logic [2*NUM_GROUPS-1:0] status_clr;
	logic [2*NUM_GROUPS-1:0] status_set;
	logic [CFG_DATA_WIDTH-1:0] rd_mux;

	assign status_set = {underflow_evt, overflow_evt};
	assign status_clr = (cfg.wr && cfg.addr == REG_STATUS) ?
		cfg.wdata[2*NUM_GROUPS-1:0] : '0;

	always_ff @(posedge read_clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			cfg_out.enable <= 1'b0;
			cfg_out.read_latency <= LAT_WIDTH'(RESET_LATENCY);
			status <= '0;
		end
		else
		begin
			// The control word maps directly onto bits 3 to 0
			if (cfg.wr && cfg.addr == REG_CTRL)
				cfg_out <= cfg.wdata[$bits(rdp_cfg_t)-1:0];
			status <= (status & ~status_clr) | status_set;
		end
	end

	// Unmapped addresses read as zero
	always_comb
	begin
		case (cfg.addr)
			REG_CTRL:   rd_mux = CFG_DATA_WIDTH'(cfg_out);
			REG_STATUS: rd_mux = CFG_DATA_WIDTH'(status);
			default:    rd_mux = '0;
		endcase
	end

	// Read data holds its last value until the next read strobe
	always_ff @(posedge read_clk or negedge arst_n)
	begin
		if (!arst_n)
			cfg_rdata <= '0;
		else if (cfg.rd)
			cfg_rdata <= rd_mux;
	end

endmodule

`default_nettype wire

// File: rtl/rdp_param_pkg.sv
/* Size constants for the two-group QDRII read path. The FIFO depth and the pointer width
   must stay consistent (PTR_WIDTH = log2(FIFO_DEPTH) + 1) */
`default_nettype none

package rdp_param_pkg;

	// Data bits carried by one DQS group
	localparam int DQ_GROUP_WIDTH = 4;
	// DQS groups served by this read path
	localparam int NUM_GROUPS = 2;
	// Full-rate words per half-rate read_clk cycle
	localparam int RATE_MULT = 2;

	// Capture words held by each per-group FIFO
	localparam int FIFO_DEPTH = 8;
	// Pointer width includes one wrap bit above the address
	localparam int PTR_WIDTH = 4;
	localparam int FIFO_ADDR_WIDTH = PTR_WIDTH - 1;

	// Read latency field and the depth of the delay line it selects into
	localparam int LAT_WIDTH = 3;
	localparam int LAT_STAGES = 1 << LAT_WIDTH;
	localparam int RESET_LATENCY = 2;

	// Register bus geometry and the register map
	localparam int CFG_ADDR_WIDTH = 2;
	localparam int CFG_DATA_WIDTH = 8;
	localparam logic [CFG_ADDR_WIDTH-1:0] REG_CTRL = 2'd0;
	localparam logic [CFG_ADDR_WIDTH-1:0] REG_STATUS = 2'd1;

endpackage

`default_nettype wire

// File: rtl/rdp_types_pkg.sv
/* Packed bundles for the read path. Slot t0 is always the oldest sample in time,
   so the slot order inside each struct runs newest first */
`default_nettype none

package rdp_types_pkg;

	import rdp_param_pkg::*;

	// One group's pair of full-rate samples
	// The rising-edge sample lands in t0 and the falling-edge sample in t1
	typedef struct packed {
		logic [DQ_GROUP_WIDTH-1:0] t1;
		logic [DQ_GROUP_WIDTH-1:0] t0;
	} capture_word_t;

	// One group's half-rate read beat made of two capture words
	typedef struct packed {
		logic [DQ_GROUP_WIDTH-1:0] t3;
		logic [DQ_GROUP_WIDTH-1:0] t2;
		logic [DQ_GROUP_WIDTH-1:0] t1;
		logic [DQ_GROUP_WIDTH-1:0] t0;
	} hr_beat_t;

	// Live configuration, laid out exactly as the control register bits 3 to 0
	typedef struct packed {
		logic enable;
		logic [LAT_WIDTH-1:0] read_latency;
	} rdp_cfg_t;

	// Simple strobed register bus in the read_clk domain
	typedef struct packed {
		logic wr;
		logic rd;
		logic [CFG_ADDR_WIDTH-1:0] addr;
		logic [CFG_DATA_WIDTH-1:0] wdata;
	} cfg_bus_t;

endpackage

`default_nettype wire

// File: rtl/read_datapath_top.sv
/* QDRII read data path for NUM_GROUPS DQS groups. Needs read_clk at half the write_clk rate,
   phase aligned, and has no strobe delay, leveling or calibration */
`timescale 1ns/1ps
`default_nettype none

module read_datapath_top
	import rdp_param_pkg::*;
	import rdp_types_pkg::*;
(
	input  wire logic write_clk,
	input  wire logic read_clk,
	input  wire logic arst_n,
	input  wire logic [NUM_GROUPS-1:0][DQ_GROUP_WIDTH-1:0] dq_in,
	input  wire logic [RATE_MULT-1:0] write_enable,
	input  wire logic read_enable,
	input  wire cfg_bus_t cfg,
	output hr_beat_t [NUM_GROUPS-1:0] rdata,
	output logic [NUM_GROUPS-1:0] rdata_valid,
	output logic [CFG_DATA_WIDTH-1:0] cfg_rdata
);

	capture_word_t [NUM_GROUPS-1:0] cap_word;
	rdp_cfg_t cfg_live;
	logic wren;
	logic rd_pop;
	logic [NUM_GROUPS-1:0] overflow_evt;
	logic [NUM_GROUPS-1:0] underflow_evt;

	ddr_capture u_capture (
		.write_clk (write_clk),
		.arst_n    (arst_n),
		.dq_in     (dq_in),
		.cap_word  (cap_word)
	);

	// One shared write strobe feeds every group, as all groups are captured together
	wren_serializer u_wren (
		.read_clk     (read_clk),
		.write_clk    (write_clk),
		.arst_n       (arst_n),
		.write_enable (write_enable),
		.wren         (wren)
	);

	for (genvar g = 0; g < NUM_GROUPS; g++)
	begin : g_group
		read_fifo_group u_fifo (
			.write_clk     (write_clk),
			.read_clk      (read_clk),
			.arst_n        (arst_n),
			.wren          (wren),
			.wr_word       (cap_word[g]),
			.rd_pop        (rd_pop),
			.rd_beat       (rdata[g]),
			.rd_valid      (rdata_valid[g]),
			.overflow_evt  (overflow_evt[g]),
			.underflow_evt (underflow_evt[g])
		);
	end

	read_enable_ctrl u_rd_ctrl (
		.read_clk    (read_clk),
		.arst_n      (arst_n),
		.read_enable (read_enable),
		.cfg         (cfg_live),
		.rd_pop      (rd_pop)
	);

	rdp_cfg_regs u_regs (
		.read_clk      (read_clk),
		.arst_n        (arst_n),
		.cfg           (cfg),
		.overflow_evt  (overflow_evt),
		.underflow_evt (underflow_evt),
		.cfg_out       (cfg_live),
		.cfg_rdata     (cfg_rdata)
	);

endmodule

`default_nettype wire

// File: rtl/read_enable_ctrl.sv
/* Read enable delay line on read_clk with a latency of 0 to 7 cycles. Reads are accepted
   every cycle, and any read sampled while the path is disabled is lost */
`timescale 1ns/1ps
`default_nettype none

module read_enable_ctrl
	import rdp_param_pkg::*;
	import rdp_types_pkg::*;
(
	input  wire logic read_clk,
	input  wire logic arst_n,
	input  wire logic read_enable,
	input  wire rdp_cfg_t cfg,
	output logic rd_pop
);

	// Stage 0 holds the read sampled at the last edge, stage n is n cycles older
	logic [LAT_STAGES-1:0] re_line;
	logic re_in;

	// Reads that arrive while disabled never enter the line
	assign re_in = read_enable & cfg.enable;

	always_ff @(posedge read_clk or negedge arst_n)
	begin
		if (!arst_n)
			re_line <= '0;
		else
			re_line <= {re_line[LAT_STAGES-2:0], re_in};
	end

	// Every stage may hold a read, so back to back reads keep their spacing
	// Clearing enable also blocks reads already in flight
	assign rd_pop = re_line[cfg.read_latency] & cfg.enable;

endmodule

`default_nettype wire

// File: rtl/read_fifo_group.sv
/* Dual-clock read FIFO for one DQS group, one word in per write_clk and two out per pop.
   Pushes into a full FIFO are dropped and a pop needs at least two words to act */
`timescale 1ns/1ps
`default_nettype none

module read_fifo_group
	import rdp_param_pkg::*;
	import rdp_types_pkg::*;
(
	input  wire logic write_clk,
	input  wire logic read_clk,
	input  wire logic arst_n,
	input  wire logic wren,
	input  wire capture_word_t wr_word,
	input  wire logic rd_pop,
	output hr_beat_t rd_beat,
	output logic rd_valid,
	output logic overflow_evt,
	output logic underflow_evt
);

	capture_word_t mem [FIFO_DEPTH];

	// Write side state in the write_clk domain
	logic [PTR_WIDTH-1:0] wr_bin;
	logic [PTR_WIDTH-1:0] wr_bin_next;
	logic [PTR_WIDTH-1:0] wr_gray;
	logic [PTR_WIDTH-1:0] rd_gray_ws1;
	logic [PTR_WIDTH-1:0] rd_gray_ws2;
	logic full;
	logic push;
	logic ovf_tog;

	// Read side state in the read_clk domain
	logic [PTR_WIDTH-1:0] rd_bin;
	logic [PTR_WIDTH-1:0] rd_gray;
	logic [PTR_WIDTH-1:0] wr_gray_rs1;
	logic [PTR_WIDTH-1:0] wr_gray_rs2;
	logic [PTR_WIDTH-1:0] wr_bin_rs;
	logic [PTR_WIDTH-1:0] rd_fill;
	logic [FIFO_ADDR_WIDTH-1:0] rd_addr;
	logic [FIFO_ADDR_WIDTH-1:0] rd_addr_next;
	logic pop_ok;
	logic [2:0] ovf_tog_rs;

	function automatic logic [PTR_WIDTH-1:0] bin_to_gray(input logic [PTR_WIDTH-1:0] b);
		return b ^ (b >> 1);
	endfunction

	function automatic logic [PTR_WIDTH-1:0] gray_to_bin(input logic [PTR_WIDTH-1:0] g);
		logic [PTR_WIDTH-1:0] b;
		b[PTR_WIDTH-1] = g[PTR_WIDTH-1];
		for (int i = PTR_WIDTH - 2; i >= 0; i--)
		begin
			b[i] = b[i+1] ^ g[i];
		end
		return b;
	endfunction

	// Full when the write pointer is one lap ahead of the synchronized read pointer
	// In gray code that is the top two bits inverted and the rest equal
	assign full = (wr_gray == {~rd_gray_ws2[PTR_WIDTH-1 -: 2], rd_gray_ws2[PTR_WIDTH-3:0]});
	assign push = wren & ~full;
	assign wr_bin_next = wr_bin + 1'b1;

	always_ff @(posedge write_clk)
	begin
		if (push)
			mem[wr_bin[FIFO_ADDR_WIDTH-1:0]] <= wr_word;
	end

	always_ff @(posedge write_clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			wr_bin <= '0;
			wr_gray <= '0;
			rd_gray_ws1 <= '0;
			rd_gray_ws2 <= '0;
			ovf_tog <= 1'b0;
		end
		else
		begin
			rd_gray_ws1 <= rd_gray;
			rd_gray_ws2 <= rd_gray_ws1;
			if (push)
			begin
				wr_bin <= wr_bin_next;
				wr_gray <= bin_to_gray(wr_bin_next);
			end
			// A dropped word flips the toggle so the event survives the crossing
			if (wren && full)
				ovf_tog <= ~ovf_tog;
		end
	end

	// Words visible to the reader, counted against the synchronized write pointer
	assign wr_bin_rs = gray_to_bin(wr_gray_rs2);
	assign rd_fill = wr_bin_rs - rd_bin;
	assign pop_ok = rd_pop && (rd_fill >= PTR_WIDTH'(RATE_MULT));
	assign rd_addr = rd_bin[FIFO_ADDR_WIDTH-1:0];
	assign rd_addr_next = rd_addr + 1'b1;

	// Older word goes to the low slots, newer word to the high slots
	always_ff @(posedge read_clk)
	begin
		if (pop_ok)
		begin
			rd_beat.t0 <= mem[rd_addr].t0;
			rd_beat.t1 <= mem[rd_addr].t1;
			rd_beat.t2 <= mem[rd_addr_next].t0;
			rd_beat.t3 <= mem[rd_addr_next].t1;
		end
	end

	always_ff @(posedge read_clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			rd_bin <= '0;
			rd_gray <= '0;
			wr_gray_rs1 <= '0;
			wr_gray_rs2 <= '0;
			rd_valid <= 1'b0;
			underflow_evt <= 1'b0;
			ovf_tog_rs <= '0;
			overflow_evt <= 1'b0;
		end
		else
		begin
			wr_gray_rs1 <= wr_gray;
			wr_gray_rs2 <= wr_gray_rs1;
			rd_valid <= pop_ok;
			underflow_evt <= rd_pop & ~pop_ok;
			if (pop_ok)
			begin
				rd_bin <= rd_bin + PTR_WIDTH'(RATE_MULT);
				rd_gray <= bin_to_gray(rd_bin + PTR_WIDTH'(RATE_MULT));
			end
			// Two flops to settle the toggle and a third to find its edge
			ovf_tog_rs <= {ovf_tog_rs[1:0], ovf_tog};
			overflow_evt <= ovf_tog_rs[2] ^ ovf_tog_rs[1];
		end
	end

endmodule

`default_nettype wire

// File: rtl/wren_serializer.sv
/* Half-rate to full-rate write enable. Assumes read_clk is write_clk divided by two with
   rising edges aligned, and the pair is consumed bit 0 first */
`timescale 1ns/1ps
`default_nettype none

module wren_serializer
	import rdp_param_pkg::*;
(
	input  wire logic read_clk,
	input  wire logic write_clk,
	input  wire logic arst_n,
	input  wire logic [RATE_MULT-1:0] write_enable,
	output logic wren
);

	// Enable pair held for a whole read_clk cycle
	logic [RATE_MULT-1:0] we_hr;
	// Flips on every read_clk edge to mark the start of a half-rate cycle
	logic hr_tog;
	// Copy of hr_tog taken on write_clk, one full-rate cycle behind
	logic hr_tog_wr;
	logic first_half;

	always_ff @(posedge read_clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			we_hr <= '0;
			hr_tog <= 1'b0;
		end
		else
		begin
			we_hr <= write_enable;
			hr_tog <= ~hr_tog;
		end
	end

	// At the write_clk edge that coincides with a read_clk edge this picks up the old toggle
	always_ff @(posedge write_clk or negedge arst_n)
	begin
		if (!arst_n)
			hr_tog_wr <= 1'b0;
		else
			hr_tog_wr <= hr_tog;
	end

	// The two toggles differ only in the first write_clk cycle of each read_clk cycle
	assign first_half = hr_tog ^ hr_tog_wr;

	// Acts like a DDIO output clocked by the half-rate clock
	assign wren = first_half ? we_hr[0] : we_hr[1];

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the read path testbench with Verilator, runs it and checks the log for a pass
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --assert -Wno-fatal \
	--top-module read_datapath_tb --Mdir "$BUILD_DIR" -f src.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/Vread_datapath_tb" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi

if grep -qx "No errors" "$LOG"; then
	echo "PASS"
	exit 0
fi
echo "FAIL"
exit 1

// File: src.f
rtl/rdp_param_pkg.sv
rtl/rdp_types_pkg.sv
rtl/ddr_capture.sv
rtl/wren_serializer.sv
rtl/read_fifo_group.sv
rtl/read_enable_ctrl.sv
rtl/rdp_cfg_regs.sv
rtl/read_datapath_top.sv
verification/read_datapath_chk.sv
verification/read_datapath_tb.sv

// File: verification/read_datapath_chk.sv
/* Concurrent checks bound into the read path top level. Everything samples on read_clk
   except the write strobe, which lives on write_clk */
`timescale 1ns/1ps
`default_nettype none

module read_datapath_chk
	import rdp_param_pkg::*;
	import rdp_types_pkg::*;
(
	input wire logic read_clk,
	input wire logic write_clk,
	input wire logic arst_n,
	input wire logic wren,
	input wire cfg_bus_t cfg,
	input wire logic [NUM_GROUPS-1:0] rdata_valid,
	input wire logic [CFG_DATA_WIDTH-1:0] cfg_rdata
);

	// Number of assertion failures seen so far
	int fail_count = 0;

	// No read data may be flagged while the path is held in reset
	valid_in_reset: assert property (@(posedge read_clk) !arst_n |-> rdata_valid == '0)
		else
		begin
			fail_count++;
			$error("rdata_valid high while arst_n is low");
		end

	// One shared rd_pop drives every group, so the valid bits move together
	valid_groups_equal: assert property (@(posedge read_clk) (&rdata_valid) == (|rdata_valid))
		else
		begin
			fail_count++;
			$error("rdata_valid differs between groups");
		end

	// Readback is registered one cycle after the strobe
	cfg_rdata_known: assert property (@(posedge read_clk) disable iff (!arst_n)
		cfg.rd |=> !$isunknown(cfg_rdata))
		else
		begin
			fail_count++;
			$error("cfg_rdata unknown after a read strobe");
		end

	wren_quiet_in_reset: assert property (@(posedge write_clk) !arst_n |-> !$rose(wren))
		else
		begin
			fail_count++;
			$error("wren rose while arst_n is low");
		end

endmodule

bind read_datapath_top read_datapath_chk u_chk (
	.read_clk    (read_clk),
	.write_clk   (write_clk),
	.arst_n      (arst_n),
	.wren        (wren),
	.cfg         (cfg),
	.rdata_valid (rdata_valid),
	.cfg_rdata   (cfg_rdata)
);

`default_nettype wire

// File: verification/read_datapath_tb.sv
/* Testbench for the two-group read path. Relies on read_clk at half the write_clk rate with
   rising edges aligned, and drives dq_in 5 ns after every write_clk edge */
`timescale 1ns/1ps
`default_nettype none

module read_datapath_tb
	import rdp_param_pkg::*;
	import rdp_types_pkg::*;
();

	localparam int READ_PERIOD = 40;
	localparam int RESET_CYCLES = 16;
	localparam int NUM_ROWS = 8;
	// Longest valid delay is latency 7 plus one, so this leaves some margin
	localparam int VALID_WAIT = 12;
	localparam int WATCHDOG_CYCLES = NUM_ROWS * 60 + RESET_CYCLES;
	localparam logic [1:0] WR_NONE = 2'd0;
	localparam logic [1:0] WR_PAIR = 2'd1;
	localparam logic [1:0] WR_SPLIT = 2'd2;

	// Each test case holds the slots per group, the control setting, the write style and
	// the status afterwards
	typedef struct packed {
		hr_beat_t [NUM_GROUPS-1:0] beat;
		logic enable;
		logic [LAT_WIDTH-1:0] latency;
		logic [1:0] wr_mode;
		logic [CFG_DATA_WIDTH-1:0] exp_status;
	} test_row_t;

	logic write_clk;
	logic read_clk;
	logic arst_n;
	logic [NUM_GROUPS-1:0][DQ_GROUP_WIDTH-1:0] dq_in;
	logic [RATE_MULT-1:0] write_enable;
	logic read_enable;
	cfg_bus_t cfg;
	hr_beat_t [NUM_GROUPS-1:0] rdata;
	logic [NUM_GROUPS-1:0] rdata_valid;
	logic [CFG_DATA_WIDTH-1:0] cfg_rdata;

	test_row_t rows [NUM_ROWS];
	// Five beats give the ten words of the overflow case
	hr_beat_t [NUM_GROUPS-1:0] ovf_beats [5];
	int error_count;

	read_datapath_top UUT (.*);

	// Both clocks come from one loop so their rising edges stay aligned
	initial
	begin
		read_clk = 1'b0;
		write_clk = 1'b0;
		#10;
		forever
		begin
			read_clk = 1'b1;
			write_clk = 1'b1;
			#10 write_clk = 1'b0;
			#10 read_clk = 1'b0;
			write_clk = 1'b1;
			#10 write_clk = 1'b0;
			#10;
		end
	end

	initial
	begin
		#(WATCHDOG_CYCLES * READ_PERIOD);
		error_count++;
		$display("Watchdog expired after %0d read_clk cycles before the tests finished",
			WATCHDOG_CYCLES);
		$display("Error count: %0d", error_count);
		$display("Errors found");
		$finish;
	end

	task automatic report_error(input string msg);
		error_count++;
		$display("Error: t=%0d ns, %s", $time, msg);
	endtask

	function automatic test_row_t make_row(input logic [LAT_WIDTH-1:0] lat, input logic en,
		input logic [1:0] mode, input logic [CFG_DATA_WIDTH-1:0] status);
		test_row_t r;
		for (int g = 0; g < NUM_GROUPS; g++)
			r.beat[g] = 16'($urandom);
		r.enable = en;
		r.latency = lat;
		r.wr_mode = mode;
		r.exp_status = status;
		return r;
	endfunction

	// Picks slot idx of every group, which is the value on dq_in for that sample
	function automatic logic [NUM_GROUPS-1:0][DQ_GROUP_WIDTH-1:0] slot_lane(
		input hr_beat_t [NUM_GROUPS-1:0] b, input int idx);
		logic [NUM_GROUPS-1:0][DQ_GROUP_WIDTH-1:0] lane;
		for (int g = 0; g < NUM_GROUPS; g++)
			lane[g] = b[g][idx*DQ_GROUP_WIDTH +: DQ_GROUP_WIDTH];
		return lane;
	endfunction

	task automatic reg_write(input logic [CFG_ADDR_WIDTH-1:0] addr,
		input logic [CFG_DATA_WIDTH-1:0] data);
		@(negedge read_clk);
		cfg.wr = 1'b1;
		cfg.addr = addr;
		cfg.wdata = data;
		@(negedge read_clk);
		cfg.wr = 1'b0;
	endtask

	// Read data is registered at the edge after the strobe, so it is ready one negedge later
	task automatic check_reg(input logic [CFG_ADDR_WIDTH-1:0] addr,
		input logic [CFG_DATA_WIDTH-1:0] exp, input string name);
		@(negedge read_clk);
		cfg.rd = 1'b1;
		cfg.addr = addr;
		@(negedge read_clk);
		cfg.rd = 1'b0;
		if (cfg_rdata !== exp)
			report_error($sformatf("%s read %h, expected %h", name, cfg_rdata, exp));
	endtask

	// Enters 5 ns before a read_clk falling edge and leaves 5 ns before the next one
	// Slots t0 and t1 feed the bit 0 word, t2 and t3 the bit 1 word of this half-rate cycle
	task automatic drive_cycle(input logic [1:0] we, input hr_beat_t [NUM_GROUPS-1:0] b);
		dq_in = slot_lane(b, 0);
		@(negedge read_clk);
		write_enable = we;
		#5 dq_in = slot_lane(b, 1);
		#10 dq_in = slot_lane(b, 2);
		#10 dq_in = slot_lane(b, 3);
		#10;
	endtask

	// The split style pushes the older word with 2'b01 and the newer one with 2'b10
	task automatic push_data(input hr_beat_t [NUM_GROUPS-1:0] b, input logic [1:0] mode);
		hr_beat_t [NUM_GROUPS-1:0] first;
		hr_beat_t [NUM_GROUPS-1:0] second;
		first = b;
		second = b;
		for (int g = 0; g < NUM_GROUPS; g++)
		begin
			first[g].t2 = ~b[g].t2;
			first[g].t3 = ~b[g].t3;
			second[g].t0 = ~b[g].t0;
			second[g].t1 = ~b[g].t1;
		end
		@(negedge read_clk);
		#35;
		if (mode == WR_PAIR)
			drive_cycle(2'b11, b);
		else
		begin
			drive_cycle(2'b01, first);
			drive_cycle(2'b10, second);
		end
		@(negedge read_clk);
		write_enable = '0;
	endtask

	// Counts read_clk edges after the one that samples read_enable until valid shows up
	task automatic read_check(input int lat, input logic expect_valid,
		input hr_beat_t [NUM_GROUPS-1:0] exp);
		int waited;
		waited = 0;
		@(negedge read_clk);
		read_enable = 1'b1;
		@(negedge read_clk);
		read_enable = 1'b0;
		while (rdata_valid == '0 && waited < VALID_WAIT)
		begin
			@(negedge read_clk);
			waited++;
		end
		if (!expect_valid)
		begin
			if (rdata_valid != '0)
				report_error("rdata_valid rose for a read that should give no data");
		end
		else if (rdata_valid == '0)
			report_error("rdata_valid never rose after read_enable");
		else
		begin
			if (waited != lat + 1)
				report_error($sformatf("valid after %0d cycles, expected %0d", waited, lat + 1));
			for (int g = 0; g < NUM_GROUPS; g++)
				if (rdata[g] !== exp[g])
					report_error($sformatf("group %0d rdata %h, expected %h", g, rdata[g], exp[g]));
		end
	endtask

	initial
	begin
		logic [CFG_DATA_WIDTH-1:0] ctrl_word;
		error_count = 0;
		arst_n = 1'b1;
		dq_in = '0;
		write_enable = '0;
		read_enable = 1'b0;
		cfg = '0;
		void'($urandom(32'h4a37_f7af));

		// Underflow rows expect both underflow bits, which sit at status bits 3 and 2
		rows[0] = make_row(3'd0, 1'b1, WR_PAIR, 8'h00);
		rows[1] = make_row(3'd3, 1'b1, WR_PAIR, 8'h00);
		rows[2] = make_row(3'd7, 1'b1, WR_PAIR, 8'h00);
		rows[3] = make_row(3'd2, 1'b1, WR_SPLIT, 8'h00);
		rows[4] = make_row(3'd5, 1'b1, WR_PAIR, 8'h00);
		rows[5] = make_row(3'd1, 1'b1, WR_NONE, 8'h0c);
		rows[6] = make_row(3'd4, 1'b0, WR_NONE, 8'h00);
		rows[7] = make_row(3'd6, 1'b1, WR_SPLIT, 8'h00);
		for (int i = 0; i < 5; i++)
			for (int g = 0; g < NUM_GROUPS; g++)
				ovf_beats[i][g] = 16'($urandom);

		#5 arst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge read_clk);
		@(negedge read_clk);
		arst_n = 1'b1;

		if (rdata_valid != '0)
			report_error("rdata_valid high after reset");
		check_reg(REG_CTRL, CFG_DATA_WIDTH'(RESET_LATENCY), "REG_CTRL after reset");
		check_reg(REG_STATUS, '0, "REG_STATUS after reset");

		foreach (rows[i])
		begin
			ctrl_word = {4'b0000, rows[i].enable, rows[i].latency};
			reg_write(REG_CTRL, ctrl_word);
			check_reg(REG_CTRL, ctrl_word, "REG_CTRL readback");
			if (rows[i].wr_mode != WR_NONE)
				push_data(rows[i].beat, rows[i].wr_mode);
			// The write pointer needs up to three cycles to reach the read side
			repeat (6) @(negedge read_clk);
			read_check(rows[i].latency, rows[i].enable && rows[i].wr_mode != WR_NONE,
				rows[i].beat);
			repeat (4) @(negedge read_clk);
			check_reg(REG_STATUS, rows[i].exp_status, "REG_STATUS after read");
			reg_write(REG_STATUS, 8'h0f);
			check_reg(REG_STATUS, '0, "REG_STATUS after clear");
		end

		// Ten words go into an eight word FIFO and the last two are dropped
		reg_write(REG_CTRL, 8'h09);
		@(negedge read_clk);
		#35;
		for (int i = 0; i < 5; i++)
			drive_cycle(2'b11, ovf_beats[i]);
		@(negedge read_clk);
		write_enable = '0;
		repeat (6) @(negedge read_clk);
		// Overflow for both groups lands in status bits 1 and 0
		check_reg(REG_STATUS, 8'h03, "REG_STATUS after overflow");
		for (int i = 0; i < 4; i++)
			read_check(1, 1'b1, ovf_beats[i]);

		// Assertion failures in the bound checker count as errors too
		error_count += UUT.u_chk.fail_count;
		$display("Error count: %0d", error_count);
		if (error_count == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire
